// File: nand_stim.txt
// start_addr stop_addr (hex) stall take (decimal)
// take 0 reads to the stop address, otherwise the next line reloads mid-run
0000010 0000017 2 0
0123450 0123453 5 0
00000FC 0000103 1 0
00003FC 0000403 0 0
2ABCDFE 2ABCE01 2 0
0000200 000020F 0 3
1F00080 1F00085 3 0
00001FD 0000210 0 3
0ABC0FF 0ABC101 2 0
0155500 0155502 0 0
0000000 0000002 1 0
3FFFFFF 3FFFFFF 1 0

// File: files.f
nand_flash_pkg.sv
nand_seq_pkg.sv
nand_bus_timing.sv
nand_addr_counter.sv
nand_read_sequencer.sv
nand_io_driver.sv
nand_flash_reader.sv
nand_flash_model.sv
tb_nand_flash_reader.sv

// File: Bender.yml
package:
  name: nand_flash_reader

sources:
  - nand_flash_pkg.sv
  - nand_seq_pkg.sv
  - nand_bus_timing.sv
  - nand_addr_counter.sv
  - nand_read_sequencer.sv
  - nand_io_driver.sv
  - nand_flash_reader.sv
  - target: test
    files:
      - nand_flash_model.sv
      - tb_nand_flash_reader.sv

// File: tb_nand_flash_reader.sv
`timescale 1ns/100ps
// ====================
// NAND flash reader testbench
// Read runs from a stimulus file against a flash
// model with data, done and pin checks
// ====================
module tb_nand_flash_reader
	import nand_flash_pkg::*;
();

	localparam int READY_TIMEOUT = 400;
	localparam int QUIET_CYCLES  = 200;
	localparam int NCE_TIMEOUT   = 20;

	logic        clk = 1'b0;
	logic        nreset;
	logic        data_request;
	logic        addr_sload;
	logic        addr_cnt_en;
	flash_addr_t addr_in;
	flash_addr_t stop_addr_in;
	logic        flash_access_granted = 1'b0;
	logic        flash_access_request;
	logic        data_ready;
	logic        done;
	flash_byte_t data;
	logic        flash_highz_io;
	flash_byte_t flash_io_in;
	flash_byte_t flash_io_out;
	logic        flash_cle;
	logic        flash_ale;
	logic        flash_noe;
	logic        flash_nwe;
	logic        flash_nce;
	logic        flash_rdy;

	always #2 clk = ~clk;

	// Arbiter grants one cycle after the request
	always @(posedge clk) begin
		flash_access_granted <= flash_access_request;
	end

	nand_flash_reader u_dut (
		.clk                  (clk),
		.nreset               (nreset),
		.flash_highz_io       (flash_highz_io),
		.flash_io_in          (flash_io_in),
		.flash_io_out         (flash_io_out),
		.flash_cle            (flash_cle),
		.flash_ale            (flash_ale),
		.flash_noe            (flash_noe),
		.flash_nwe            (flash_nwe),
		.flash_nce            (flash_nce),
		.flash_rdy            (flash_rdy),
		.data_request         (data_request),
		.data_ready           (data_ready),
		.data                 (data),
		.addr_in              (addr_in),
		.stop_addr_in         (stop_addr_in),
		.addr_sload           (addr_sload),
		.addr_cnt_en          (addr_cnt_en),
		.done                 (done),
		.flash_access_request (flash_access_request),
		.flash_access_granted (flash_access_granted)
	);

	nand_flash_model u_flash (
		.clk        (clk),
		.flash_nce  (flash_nce),
		.flash_cle  (flash_cle),
		.flash_ale  (flash_ale),
		.flash_nwe  (flash_nwe),
		.flash_noe  (flash_noe),
		.flash_din  (flash_io_out),
		.flash_dout (flash_io_in),
		.flash_rdy  (flash_rdy)
	);

	// ====================
	// Checks
	// ====================
	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	// Array content rule of the device
	function automatic flash_byte_t expected_byte(input flash_addr_t a);
		return a[7:0] ^ a[16:9] ^ a[24:17];
	endfunction

	task automatic check_reset_levels();
		check_value(flash_nce, 1, "nce after reset");
		check_value(flash_nwe, 1, "nwe after reset");
		check_value(flash_noe, 1, "noe after reset");
		check_value(flash_cle, 0, "cle after reset");
		check_value(flash_ale, 0, "ale after reset");
		check_value(flash_highz_io, 1, "bus release after reset");
		check_value(data_ready, 0, "data_ready after reset");
		check_value(done, 0, "done after reset");
		check_value(flash_access_request, 0, "access request after reset");
	endtask

	// Latch enables only with the chip selected, never both
	always @(negedge clk) begin
		if (nreset === 1'b1) begin
			check_value(flash_cle & flash_ale, 0, "cle and ale high together");
			check_value((flash_cle | flash_ale) & flash_nce, 0, "latch enable with nce high");
			// Bus driven for write strobes, released for read strobes
			check_value(!flash_nwe & flash_highz_io, 0, "bus released during a write strobe");
			check_value(!flash_noe & !flash_highz_io, 0, "bus driven during a read strobe");
		end
	end

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (data_ready !== 1'b1) begin
			cycles++;
			if (cycles > READY_TIMEOUT) begin
				$display("Timeout at %0t ns: data_ready did not rise within %0d cycles",
					$time, READY_TIMEOUT);
				abort_run();
			end
			@(negedge clk);
		end
	endtask

	// ====================
	// Consumer
	// ====================
	task automatic take_byte(input flash_addr_t addr, input flash_addr_t stop, input int stall);
		flash_byte_t held;
		int          hold_cycles;
		wait_ready();
		check_value(data, expected_byte(addr), "read data");
		check_value(done, addr == stop, "done at data_ready");
		check_value(u_flash.read_addr, flash_addr_t'(addr + 1'b1), "flash address after read");
		held        = data;
		hold_cycles = stall + int'($urandom % 4);
		repeat (hold_cycles) begin
			@(negedge clk);
			check_value(data_ready, 1, "data_ready during stall");
			check_value(data, held, "data during stall");
		end
		@(posedge clk);
		addr_cnt_en <= 1'b1;
		@(posedge clk);
		addr_cnt_en <= 1'b0;
	endtask

	// A take count of zero reads through to the stop address
	task automatic read_run(input flash_addr_t start, input flash_addr_t stop, input int stall,
		input int take);
		flash_addr_t addr;
		int          count;
		@(posedge clk);
		addr_in      <= start;
		stop_addr_in <= stop;
		addr_sload   <= 1'b1;
		@(posedge clk);
		addr_sload <= 1'b0;
		count = (take == 0) ? int'(stop - start) + 1 : take;
		addr  = start;
		repeat (count) begin
			take_byte(addr, stop, stall);
			addr = addr + 1'b1;
		end
		// Session closed until the next load
		if (take == 0) begin
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				check_value(data_ready, 0, "data_ready after the stop address");
			end
			check_value(done, 0, "done past the stop address");
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int          fd;
		int          got;
		int          runs;
		int          stall;
		int          take;
		int          cycles;
		flash_addr_t start;
		flash_addr_t stop;
		string       line;
		nreset       = 1'b0;
		data_request = 1'b0;
		addr_sload   = 1'b0;
		addr_cnt_en  = 1'b0;
		addr_in      = '0;
		stop_addr_in = '0;
		runs         = 0;
		void'($urandom(86));
		repeat (4) @(posedge clk);
		nreset <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_reset_levels();
		end
		@(posedge clk);
		data_request <= 1'b1;
		fd = $fopen("nand_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file nand_stim.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			if ((got == 0) || (line.len() == 0) || (line[0] == "/")) begin
				continue;
			end
			if ($sscanf(line, "%h %h %d %d", start, stop, stall, take) == 4) begin
				read_run(start, stop, stall, take);
				runs++;
			end
		end
		$fclose(fd);
		if (runs == 0) begin
			$display("The stimulus file held no read runs");
			abort_run();
		end
		// Release the flash and wait for the chip to be deselected
		@(posedge clk);
		data_request <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (flash_nce !== 1'b1) begin
			cycles++;
			if (cycles > NCE_TIMEOUT) begin
				$display("Timeout at %0t ns: nce did not return high after the request fell",
					$time);
				abort_run();
			end
			@(negedge clk);
		end
		check_value(flash_access_request, 0, "access request after release");
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: nand_flash_model.sv
`timescale 1ns/100ps
// ====================
// NAND flash model
// Small-page x8 read behavior with command and
// address latch, busy time and a computed data pattern
// ====================
module nand_flash_model
	import nand_flash_pkg::*;
(
	input  logic        clk,
	input  logic        flash_nce,
	input  logic        flash_cle,
	input  logic        flash_ale,
	input  logic        flash_nwe,
	input  logic        flash_noe,
	input  flash_byte_t flash_din,
	output flash_byte_t flash_dout,
	output logic        flash_rdy
);

	flash_byte_t addr_bytes [FLASH_ADDR_CYCLE-1];
	logic        upper_half = 1'b0;
	int          addr_idx   = FLASH_ADDR_CYCLE;
	int          busy_cnt   = 0;
	logic        nwe_q      = 1'b1;
	logic        noe_q      = 1'b1;
	flash_addr_t read_addr  = '0;

	// Array content as a function of the byte address
	function automatic flash_byte_t stored_byte(input flash_addr_t a);
		return a[7:0] ^ a[16:9] ^ a[24:17];
	endfunction

	assign flash_dout = stored_byte(read_addr);
	assign flash_rdy  = (busy_cnt == 0);

	// Strobe edges seen one clock late while the bus still holds the byte
	always @(posedge clk) begin
		nwe_q <= flash_nwe;
		noe_q <= flash_noe;
		if (busy_cnt != 0) begin
			busy_cnt <= busy_cnt - 1;
		end
		// Sequential read through the array
		if (!noe_q && flash_noe) begin
			read_addr <= read_addr + 1'b1;
		end
		if (!nwe_q && flash_nwe && !flash_nce) begin
			if (flash_cle) begin
				upper_half <= (flash_din == CMD_READ_HIGH);
				addr_idx   <= 0;
			end else if (flash_ale && (addr_idx < FLASH_ADDR_CYCLE - 1)) begin
				addr_bytes[addr_idx] <= flash_din;
				addr_idx             <= addr_idx + 1;
			end else if (flash_ale && (addr_idx == FLASH_ADDR_CYCLE - 1)) begin
				// Last address byte starts the page load
				read_addr <= {flash_din[0], addr_bytes[2], addr_bytes[1], upper_half,
					addr_bytes[0]};
				addr_idx  <= FLASH_ADDR_CYCLE;
				busy_cnt  <= $urandom_range(40, 10);
			end
		end
	end

endmodule

// File: nand_flash_reader.sv
`timescale 1ns/100ps
// ====================
// NAND flash page reader
// Configuration data reader for a small-page x8 device
// ====================
module nand_flash_reader
	import nand_flash_pkg::*;
	import nand_seq_pkg::*;
(
	input  logic        clk,
	input  logic        nreset,
	// Flash pins
	output logic        flash_highz_io,
	input  flash_byte_t flash_io_in,
	output flash_byte_t flash_io_out,
	output logic        flash_cle,
	output logic        flash_ale,
	output logic        flash_noe,
	output logic        flash_nwe,
	output logic        flash_nce,
	input  logic        flash_rdy,
	// Consumer
	input  logic        data_request,
	output logic        data_ready,
	output flash_byte_t data,
	input  flash_addr_t addr_in,
	input  flash_addr_t stop_addr_in,
	input  logic        addr_sload,
	input  logic        addr_cnt_en,
	output logic        done,
	// Arbiter
	output logic        flash_access_request,
	input  logic        flash_access_granted
);

	bus_phase_t  phase;
	op_cnt_t     op_count;
	flash_byte_t addr_byte;
	logic        strobe_low;
	logic        phase_end;
	logic        state_change;
	logic        reopen;
	logic        half_sel;
	logic        granted;

	nand_bus_timing u_bus_timing (
		.clk          (clk),
		.nreset       (nreset),
		.phase        (phase),
		.state_change (state_change),
		.strobe_low   (strobe_low),
		.phase_end    (phase_end),
		.op_count     (op_count)
	);

	nand_addr_counter u_addr_counter (
		.clk          (clk),
		.nreset       (nreset),
		.addr_sload   (addr_sload),
		.addr_cnt_en  (addr_cnt_en),
		.addr_in      (addr_in),
		.stop_addr_in (stop_addr_in),
		.op_count     (op_count),
		.reopen       (reopen),
		.done         (done),
		.half_sel     (half_sel),
		.addr_byte    (addr_byte)
	);

	nand_read_sequencer u_sequencer (
		.clk                  (clk),
		.nreset               (nreset),
		.data_request         (data_request),
		.flash_access_granted (flash_access_granted),
		.flash_rdy            (flash_rdy),
		.phase_end            (phase_end),
		.reopen               (reopen),
		.done                 (done),
		.byte_taken           (addr_cnt_en),
		.op_count             (op_count),
		.phase                (phase),
		.state_change         (state_change),
		.flash_access_request (flash_access_request),
		.granted              (granted),
		.read_pending         ()
	);

	nand_io_driver u_io_driver (
		.clk            (clk),
		.nreset         (nreset),
		.granted        (granted),
		.strobe_low     (strobe_low),
		.phase_end      (phase_end),
		.half_sel       (half_sel),
		.byte_taken_in  (addr_cnt_en),
		.phase          (phase),
		.addr_byte      (addr_byte),
		.flash_io_in    (flash_io_in),
		.flash_cle      (flash_cle),
		.flash_ale      (flash_ale),
		.flash_nwe      (flash_nwe),
		.flash_noe      (flash_noe),
		.flash_nce      (flash_nce),
		.flash_highz_io (flash_highz_io),
		.data_ready     (data_ready),
		.flash_io_out   (flash_io_out),
		.data           (data)
	);

endmodule

// File: nand_io_driver.sv
`timescale 1ns/100ps
// ====================
// NAND pin driver
// Registered control pins and bus, read
// capture and consumer ready
// ====================
module nand_io_driver
	import nand_flash_pkg::*;
	import nand_seq_pkg::*;
(
	input  logic        clk,
	input  logic        nreset,
	input  logic        granted,
	input  logic        strobe_low,
	input  logic        phase_end,
	input  logic        half_sel,
	input  logic        byte_taken_in,
	input  bus_phase_t  phase,
	input  flash_byte_t addr_byte,
	input  flash_byte_t flash_io_in,
	output logic        flash_cle,
	output logic        flash_ale,
	output logic        flash_nwe,
	output logic        flash_noe,
	output logic        flash_nce,
	output logic        flash_highz_io,
	output logic        data_ready,
	output flash_byte_t flash_io_out,
	output flash_byte_t data
);

	logic        write_phase;
	logic        byte_valid;
	logic        rdy_clear;
	logic        rdy_stage1;
	logic        rdy_stage2;
	flash_byte_t bus_next;

	assign write_phase = (phase == PH_CMD) || (phase == PH_ADDR);
	assign byte_valid  = (phase == PH_READ) && phase_end;
	assign bus_next    = (phase == PH_CMD) ? (half_sel ? CMD_READ_HIGH : CMD_READ_LOW) : addr_byte;
	assign rdy_clear   = byte_taken_in || !granted || (phase != PH_NONE);
	// Hidden as soon as a page open starts
	assign data_ready  = rdy_stage2 && (phase == PH_NONE);

	// Pins lag the phase by one clock, so the strobe rises on the phase edge
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			flash_nce      <= 1'b1;
			flash_cle      <= 1'b0;
			flash_ale      <= 1'b0;
			flash_nwe      <= 1'b1;
			flash_noe      <= 1'b1;
			flash_highz_io <= 1'b1;
		end else begin
			flash_nce      <= !granted;
			flash_cle      <= (phase == PH_CMD);
			flash_ale      <= (phase == PH_ADDR);
			flash_nwe      <= !(write_phase && strobe_low);
			flash_noe      <= !((phase == PH_READ) && strobe_low);
			flash_highz_io <= !write_phase;
		end
	end

	// Byte sampled before noe rises
	always_ff @(posedge clk) begin
		flash_io_out <= bus_next;
		if (byte_valid) begin
			data <= flash_io_in;
		end
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			rdy_stage1 <= 1'b0;
			rdy_stage2 <= 1'b0;
		end else begin
			if (byte_valid) begin
				rdy_stage1 <= 1'b1;
			end else if (rdy_clear) begin
				rdy_stage1 <= 1'b0;
			end
			rdy_stage2 <= rdy_stage1 && !rdy_clear;
		end
	end

	a_capture_with_noe_low: assert property (@(posedge clk) disable iff (!nreset)
		byte_valid |-> !flash_noe)
		else $error("read byte captured with noe high");
	a_latch_needs_nce: assert property (@(posedge clk) disable iff (!nreset)
		(flash_cle || flash_ale) |-> !flash_nce)
		else $error("latch enable without chip enable");

endmodule

// File: nand_read_sequencer.sv
`timescale 1ns/100ps
// ====================
// NAND read sequencer
// Arbiter handshake and the page open,
// busy wait and byte read FSM
// ====================
module nand_read_sequencer
	import nand_flash_pkg::*;
	import nand_seq_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  logic       data_request,
	input  logic       flash_access_granted,
	input  logic       flash_rdy,
	input  logic       phase_end,
	input  logic       reopen,
	input  logic       done,
	input  logic       byte_taken,
	input  op_cnt_t    op_count,
	output bus_phase_t phase,
	output logic       state_change,
	output logic       flash_access_request,
	output logic       granted,
	output logic       read_pending
);

	seq_state_t state;
	seq_state_t next_state;
	logic       armed;
	logic       session_end;

	// Consumer took the byte at the stop address
	assign session_end = byte_taken && done;

	// ====================
	// Arbiter handshake
	// ====================
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			flash_access_request <= 1'b0;
			granted              <= 1'b0;
		end else begin
			flash_access_request <= data_request;
			if (!data_request) begin
				granted <= 1'b0;
			end else if (!granted) begin
				granted <= flash_access_granted;
			end
		end
	end

	// ====================
	// Read FSM
	// ====================
	always_comb begin
		next_state = state;
		if ((state != S_IDLE) && !data_request) begin
			next_state = S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (data_request && granted && armed) begin
						next_state = S_CMD;
					end
				end
				S_CMD: begin
					if (reopen) begin
						next_state = S_CMD;
					end else if (phase_end) begin
						next_state = S_ADDR;
					end
				end
				S_ADDR: begin
					if (reopen) begin
						next_state = S_CMD;
					end else if (phase_end && (op_count == FLASH_ADDR_CYCLE - 1)) begin
						next_state = S_WAIT;
					end
				end
				S_WAIT: begin
					if (reopen) begin
						next_state = S_CMD;
					end else if (phase_end && flash_rdy &&
						(op_count >= WAIT_MIN_PHASES - 1)) begin
						next_state = S_DATA;
					end
				end
				S_DATA: begin
					if (session_end) begin
						next_state = S_IDLE;
					end else if (reopen) begin
						next_state = S_CMD;
					end
				end
				default: next_state = S_IDLE;
			endcase
		end
	end

	// A reload during CMD restarts the same state
	assign state_change = (next_state != state) || ((state == S_CMD) && reopen);

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			state        <= S_IDLE;
			armed        <= 1'b0;
			read_pending <= 1'b0;
		end else begin
			state <= next_state;
			if ((state == S_DATA) && session_end) begin
				armed <= 1'b0;
			end else if (reopen) begin
				armed <= 1'b1;
			end
			// First byte on entry, then one per consumed byte
			read_pending <= (next_state == S_DATA) &&
				((state != S_DATA) || byte_taken || (read_pending && !phase_end));
		end
	end

	always_comb begin
		case (state)
			S_CMD:   phase = PH_CMD;
			S_ADDR:  phase = PH_ADDR;
			S_WAIT:  phase = PH_WAIT;
			S_DATA:  phase = read_pending ? PH_READ : PH_NONE;
			default: phase = PH_NONE;
		endcase
	end

endmodule

// File: nand_addr_counter.sv
`timescale 1ns/100ps
// ====================
// NAND logical address counter
// Load and advance, half and page crossing,
// stop compare and address cycle bytes
// ====================
module nand_addr_counter
	import nand_flash_pkg::*;
	import nand_seq_pkg::*;
(
	input  logic        clk,
	input  logic        nreset,
	input  logic        addr_sload,
	input  logic        addr_cnt_en,
	input  flash_addr_t addr_in,
	input  flash_addr_t stop_addr_in,
	input  op_cnt_t     op_count,
	output logic        reopen,
	output logic        done,
	output logic        half_sel,
	output flash_byte_t addr_byte
);

	flash_addr_t addr_q;
	flash_addr_t addr_next;
	logic        loaded;
	logic        next_half;
	logic        next_page;

	// Last byte of lower half, or last byte of page
	assign next_half = addr_cnt_en && !addr_q[COL_ADDR_WIDTH-1] &&
		(&addr_q[COL_ADDR_WIDTH-2:0]);
	assign next_page = addr_cnt_en && (&addr_q[COL_ADDR_WIDTH-1:0]);
	assign reopen    = addr_sload || next_half || next_page;
	assign half_sel  = addr_q[COL_ADDR_WIDTH-1];

	always_comb begin
		if (addr_sload) begin
			addr_next = addr_in;
		end else if (addr_cnt_en) begin
			addr_next = addr_q + 1'b1;
		end else begin
			addr_next = addr_q;
		end
	end

	// Done compares the next address so it tracks addr_q exactly
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			addr_q <= '0;
			loaded <= 1'b0;
			done   <= 1'b0;
		end else begin
			addr_q <= addr_next;
			loaded <= loaded || addr_sload;
			done   <= (loaded || addr_sload) && (addr_next == stop_addr_in);
		end
	end

	// Column low byte, then row bytes
	always_comb begin
		case (op_count)
			8'd0:    addr_byte = addr_q[7:0];
			8'd1:    addr_byte = addr_q[COL_ADDR_WIDTH+7:COL_ADDR_WIDTH];
			8'd2:    addr_byte = addr_q[COL_ADDR_WIDTH+15:COL_ADDR_WIDTH+8];
			default: addr_byte = flash_byte_t'(addr_q[FLASH_ADDR_WIDTH-1:COL_ADDR_WIDTH+16]);
		endcase
	end

	a_load_or_count: assert property (@(posedge clk) disable iff (!nreset)
		!(addr_sload && addr_cnt_en))
		else $error("address load and advance in the same cycle");

endmodule

// File: nand_bus_timing.sv
`timescale 1ns/100ps
// ====================
// NAND bus timing
// Slow flash clock within a phase and a
// count of phases done in the current state
// ====================
module nand_bus_timing
	import nand_flash_pkg::*;
	import nand_seq_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  bus_phase_t phase,
	input  logic       state_change,
	output logic       strobe_low,
	output logic       phase_end,
	output op_cnt_t    op_count
);

	phase_cnt_t clk_cnt;
	logic       active;

	assign active     = (phase != PH_NONE);
	assign strobe_low = active && (clk_cnt < LOW_CYCLES);
	assign phase_end  = active && (clk_cnt == phase_cnt_t'(CLK_DIVISOR - 1));

	// Clock within the phase, restarts with every new state
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			clk_cnt <= '0;
		end else if (!active || state_change || phase_end) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Completed phases, held at the top on long waits
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			op_count <= '0;
		end else if (!active || state_change) begin
			op_count <= '0;
		end else if (phase_end && (op_count != '1)) begin
			op_count <= op_count + 1'b1;
		end
	end

	a_phase_starts_at_zero: assert property (@(posedge clk) disable iff (!nreset)
		(phase != $past(phase)) |-> (clk_cnt == '0))
		else $error("bus phase changed in the middle of a phase");

endmodule

// File: nand_seq_pkg.sv
// ====================
// Read sequencer package
// State and bus phase types
// ====================
package nand_seq_pkg;

	import nand_flash_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_CMD,
		S_ADDR,
		S_WAIT,
		S_DATA
	} seq_state_t;

	// Pin activity asked of timing and driver
	typedef enum logic [2:0] {
		PH_NONE,
		PH_CMD,
		PH_ADDR,
		PH_WAIT,
		PH_READ
	} bus_phase_t;

	typedef logic [$clog2(CLK_DIVISOR)-1:0] phase_cnt_t;
	typedef logic [7:0] op_cnt_t;

endpackage

// File: nand_flash_pkg.sv
// ====================
// NAND flash device package
// Geometry of the small-page x8 device,
// read commands and bus pacing constants
// ====================
package nand_flash_pkg;

	// ====================
	// Geometry
	// ====================
	localparam int FLASH_ADDR_WIDTH = 26;
	localparam int FLASH_DATA_WIDTH = 8;
	// 512-byte page, 32 pages per block
	localparam int COL_ADDR_WIDTH   = 9;
	localparam int PAGE_ADDR_WIDTH  = 5;
	localparam int FLASH_ADDR_CYCLE = 4;

	typedef logic [FLASH_ADDR_WIDTH-1:0] flash_addr_t;
	typedef logic [FLASH_DATA_WIDTH-1:0] flash_byte_t;

	// Read command per half page
	localparam flash_byte_t CMD_READ_LOW  = 8'h00;
	localparam flash_byte_t CMD_READ_HIGH = 8'h01;

	// ====================
	// Bus pacing
	// ====================
	localparam int CLK_DIVISOR     = 4;
	localparam int LOW_CYCLES      = 3;
	localparam int WAIT_MIN_PHASES = 8;

endpackage
